// ==== sm_config.f ====
+incdir+.
sm_pkg.sv
sm_reg_decode.sv
sm_port_ctrl.sv
sm_readback.sv
sm_config_top.sv
tb_sm_config.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sm_config testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sm_config.f \
  --top-module tb_sm_config -o tb_sm_config_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sm_config_sim)
run_status=$?
echo "$out"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
echo "pass message not found"
exit 1

// ==== tb_sm_config.sv ====
`timescale 1ns/1ns
`include "sm_consts.svh"

module tb_sm_config;

  localparam int N_RAND = 40;
  localparam int N_DATA = 260; // enough bytes to wrap the counter
  localparam int XFERS  = 12 + 7 * N_RAND + 2 * N_DATA;
  localparam int LIMIT  = XFERS * 8 + 200;

  logic       epb_clk;
  logic       wb_rst;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [2:0] wb_adr;
  logic [7:0] wb_dat;
  logic [7:0] wb_dat_o;
  logic       wb_ack_o;
  logic       sm_cs_n;
  logic       sm_busy;
  logic       v5c_done;
  logic       v5c_busy;
  logic       v5c_init_n;
  logic [7:0] v5c_d_o;
  logic       v5c_cs_n_o;
  logic       v5c_prog_n_o;
  logic       v5c_rdwr_n_o;
  logic       v5c_init_n_o;
  logic       v5c_init_n_oen_o;
  logic [2:0] v5c_mode_o;

  // reference model
  logic       m_prog = 1'b1;
  logic       m_init_o = 1'b1;
  logic       m_rdwr = 1'b0;
  logic       m_oen = 1'b1;
  logic [7:0] m_count = 8'd0;
  logic       m_crc = 1'b0;
  logic       m_sm_busy = 1'b0;
  logic       m_v5c_busy = 1'b0;
  logic       m_v5c_done = 1'b0;
  logic       m_init_n = 1'b1;

  logic [31:0] lfsr_q = 32'ha4e4;
  int          cycle_cnt;
  int          ack_cnt = 0;
  int          cs_cnt = 0;
  logic [7:0]  cs_byte;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          test_num = 0;
  int          test_err = 0;

  sm_config_top sm_config_top_inst (
    .epb_clk          (epb_clk),
    .wb_rst_i         (wb_rst),
    .wb_cyc_i         (wb_cyc),
    .wb_stb_i         (wb_stb),
    .wb_we_i          (wb_we),
    .wb_adr_i         (wb_adr),
    .wb_dat_i         (wb_dat),
    .wb_dat_o         (wb_dat_o),
    .wb_ack_o         (wb_ack_o),
    .sm_cs_n_i        (sm_cs_n),
    .sm_busy_i        (sm_busy),
    .v5c_done_i       (v5c_done),
    .v5c_busy_i       (v5c_busy),
    .v5c_init_n_i     (v5c_init_n),
    .v5c_d_o          (v5c_d_o),
    .v5c_cs_n_o       (v5c_cs_n_o),
    .v5c_prog_n_o     (v5c_prog_n_o),
    .v5c_rdwr_n_o     (v5c_rdwr_n_o),
    .v5c_init_n_o     (v5c_init_n_o),
    .v5c_init_n_oen_o (v5c_init_n_oen_o),
    .v5c_mode_o       (v5c_mode_o)
  );

  initial begin
    epb_clk = 1'b0;
    forever #10 epb_clk = ~epb_clk;
  end

  always @(posedge epb_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("timeout: no result after %0d clock cycles", cycle_cnt);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // counts acks and chip-select low cycles
  always @(negedge epb_clk) begin
    if (!wb_rst) begin
      if (wb_ack_o)
        ack_cnt++;
      if (!v5c_cs_n_o) begin
        cs_cnt++;
        cs_byte = v5c_d_o;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // galois lfsr, one step per bit
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic void update_crc();
    if (!m_init_n && m_prog && m_count != 8'd0)
      m_crc = 1'b1;
  endfunction

  function automatic void model_write(input logic [2:0] adr, input logic [7:0] dat);
    case (adr)
      `SM_REG_OREGS: begin
        m_prog   = dat[0];
        m_init_o = dat[1];
        m_rdwr   = dat[2];
        if (!dat[0])
          m_count = 8'd0;
      end
      `SM_REG_DATA: m_count = m_count + 8'd1;
      `SM_REG_CTRL: begin
        m_oen = dat[0];
        if (dat[1])
          m_crc = 1'b0;
      end
      default: ;
    endcase
    update_crc();
  endfunction

  function automatic logic [7:0] exp_read(input logic [2:0] adr);
    case (adr)
      `SM_REG_STATUS: return {3'b0, m_crc, m_sm_busy, m_v5c_busy, m_v5c_done, m_init_n};
      `SM_REG_OREGS:  return {5'b0, m_rdwr, m_init_o, m_prog};
      `SM_REG_CTRL:   return {7'b0, m_oen};
      `SM_REG_COUNT:  return m_count;
      default:        return 8'd0;
    endcase
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic finish_test(input string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, test_err);
    test_err = 0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // wishbone master, strobe held until ack plus hold cycles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic wb_xfer(input logic we, input logic [2:0] adr, input logic [7:0] dat,
                         input int hold, output logic [7:0] rdata);
    @(posedge epb_clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= we;
    wb_adr <= adr;
    wb_dat <= dat;
    @(negedge epb_clk);
    while (!wb_ack_o)
      @(negedge epb_clk);
    rdata = wb_dat_o;
    repeat (hold) @(negedge epb_clk);
    @(posedge epb_clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_reg(input logic [2:0] adr, input logic [7:0] dat);
    logic [7:0] rd;
    wb_xfer(1'b1, adr, dat, 0, rd);
    model_write(adr, dat);
  endtask

  task automatic read_check(input logic [2:0] adr, input string what);
    logic [7:0] rd;
    wb_xfer(1'b0, adr, 8'h00, 0, rd);
    check(what, 32'(rd), 32'(exp_read(adr)));
  endtask

  task automatic check_pins();
    check("prog_n pin", 32'(v5c_prog_n_o), 32'(m_prog));
    check("init_n pin", 32'(v5c_init_n_o), 32'(m_init_o));
    check("rdwr_n pin", 32'(v5c_rdwr_n_o), 32'(m_rdwr));
    check("init_n_oen pin", 32'(v5c_init_n_oen_o), 32'(m_oen));
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] b;
    logic [7:0]  rd;
    int          i;
    int          c0;
    int          a0;
    wb_rst     <= 1'b1;
    wb_cyc     <= 1'b0;
    wb_stb     <= 1'b0;
    wb_we      <= 1'b0;
    wb_adr     <= 3'd0;
    wb_dat     <= 8'd0;
    sm_cs_n    <= 1'b1;
    sm_busy    <= 1'b0;
    v5c_done   <= 1'b0;
    v5c_busy   <= 1'b0;
    v5c_init_n <= 1'b1;
    cycle_cnt  <= 0;
    repeat (5) @(posedge epb_clk);
    wb_rst <= 1'b0;
    @(negedge epb_clk);

    check("cs_n after reset", 32'(v5c_cs_n_o), 32'd1);
    check("ack after reset", 32'(wb_ack_o), 32'd0);
    check("mode pins", 32'(v5c_mode_o), 32'(3'b110));
    check_pins();
    for (i = 0; i < 5; i++)
      read_check(3'(i), "reset read");
    finish_test("reset values");

    for (i = 0; i < N_RAND; i++) begin
      r = rand_bits(9);
      if (r[8])
        write_reg(`SM_REG_OREGS, r[7:0]);
      else
        write_reg(`SM_REG_CTRL, r[7:0]);
      @(negedge epb_clk);
      check_pins();
      read_check(`SM_REG_OREGS, "oregs read");
      read_check(`SM_REG_CTRL, "ctrl read");
    end
    finish_test("oregs and ctrl writes");

    for (i = 0; i < N_DATA; i++) begin
      r  = rand_bits(8);
      c0 = cs_cnt;
      write_reg(`SM_REG_DATA, r[7:0]);
      read_check(`SM_REG_COUNT, "count read");
      check("cs_n low cycles", cs_cnt - c0, 32'd1);
      check("byte under cs_n", 32'(cs_byte), 32'(r[7:0]));
    end
    write_reg(`SM_REG_OREGS, {5'b0, m_rdwr, m_init_o, 1'b0});
    read_check(`SM_REG_COUNT, "count after prog_n low");
    write_reg(`SM_REG_OREGS, {5'b0, m_rdwr, m_init_o, 1'b1});
    finish_test("data writes");

    for (i = 0; i < N_RAND; i++) begin
      r = rand_bits(5);
      @(posedge epb_clk);
      sm_busy    <= r[0];
      v5c_busy   <= r[1];
      v5c_done   <= r[2];
      v5c_init_n <= (r[4:3] != 2'b00); // low one time in four
      m_sm_busy  = r[0];
      m_v5c_busy = r[1];
      m_v5c_done = r[2];
      m_init_n   = (r[4:3] != 2'b00);
      update_crc();
      r = rand_bits(1);
      if (r[0]) begin
        b = rand_bits(8);
        write_reg(`SM_REG_DATA, b[7:0]);
      end
      read_check(`SM_REG_STATUS, "status read");
      r = rand_bits(2);
      if (r[1:0] == 2'b00)
        write_reg(`SM_REG_CTRL, {6'b0, 1'b1, m_oen});
    end
    @(posedge epb_clk);
    sm_busy    <= 1'b0;
    v5c_busy   <= 1'b0;
    v5c_done   <= 1'b0;
    v5c_init_n <= 1'b1;
    m_sm_busy  = 1'b0;
    m_v5c_busy = 1'b0;
    m_v5c_done = 1'b0;
    m_init_n   = 1'b1;
    write_reg(`SM_REG_CTRL, {6'b0, 1'b1, m_oen});
    read_check(`SM_REG_STATUS, "status after crc clear");
    finish_test("status and crc_err");

    for (i = 0; i < N_RAND; i++) begin
      c0 = cs_cnt;
      @(posedge epb_clk);
      sm_cs_n <= 1'b0;
      @(negedge epb_clk);
      check("cs_n during serial strobe", 32'(v5c_cs_n_o), 32'd0);
      @(posedge epb_clk);
      sm_cs_n <= 1'b1;
      @(negedge epb_clk);
      check("cs_n after serial strobe", 32'(v5c_cs_n_o), 32'd1);
      @(posedge epb_clk);
      check("serial cs_n cycles", cs_cnt - c0, 32'd1);
      r = rand_bits(2);
      repeat (r[1:0]) @(posedge epb_clk);
    end
    finish_test("serial chip select");

    r  = rand_bits(8);
    a0 = ack_cnt;
    c0 = cs_cnt;
    wb_xfer(1'b1, `SM_REG_DATA, r[7:0], 5, rd);
    model_write(`SM_REG_DATA, r[7:0]);
    repeat (3) @(posedge epb_clk);
    check("acks for held strobe", ack_cnt - a0, 32'd1);
    check("bytes for held strobe", cs_cnt - c0, 32'd1);
    check("byte on bus", 32'(v5c_d_o), 32'(r[7:0]));
    read_check(`SM_REG_COUNT, "count after held strobe");
    finish_test("held strobe");

    $display("%0d tests, %0d checks, %0d errors", test_num, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== sm_config_top.sv ====
`timescale 1ns/1ns

module sm_config_top (
  input  logic       epb_clk,
  input  logic       wb_rst_i,
  input  logic       wb_cyc_i,
  input  logic       wb_stb_i,
  input  logic       wb_we_i,
  input  logic [2:0] wb_adr_i,
  input  logic [7:0] wb_dat_i,
  output logic [7:0] wb_dat_o,
  output logic       wb_ack_o,
  input  logic       sm_cs_n_i,
  input  logic       sm_busy_i,  // serial interface owns the bus
  input  logic       v5c_done_i,
  input  logic       v5c_busy_i,
  input  logic       v5c_init_n_i,
  output logic [7:0] v5c_d_o,
  output logic       v5c_cs_n_o,
  output logic       v5c_prog_n_o,
  output logic       v5c_rdwr_n_o,
  output logic       v5c_init_n_o,
  output logic       v5c_init_n_oen_o,
  output logic [2:0] v5c_mode_o
);
  import sm_pkg::*;

  sm_cmd_t    cmd;
  sm_pins_t   pins;
  sm_status_t status;
  logic [7:0] byte_count;

  sm_reg_decode sm_reg_decode_inst (
    .epb_clk  (epb_clk),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_o),
    .cmd_o    (cmd)
  );

  sm_port_ctrl sm_port_ctrl_inst (
    .epb_clk          (epb_clk),
    .wb_rst_i         (wb_rst_i),
    .cmd_i            (cmd),
    .sm_cs_n_i        (sm_cs_n_i),
    .sm_busy_i        (sm_busy_i),
    .v5c_done_i       (v5c_done_i),
    .v5c_busy_i       (v5c_busy_i),
    .v5c_init_n_i     (v5c_init_n_i),
    .pins_o           (pins),
    .status_o         (status),
    .byte_count_o     (byte_count),
    .v5c_d_o          (v5c_d_o),
    .v5c_cs_n_o       (v5c_cs_n_o),
    .v5c_prog_n_o     (v5c_prog_n_o),
    .v5c_rdwr_n_o     (v5c_rdwr_n_o),
    .v5c_init_n_o     (v5c_init_n_o),
    .v5c_init_n_oen_o (v5c_init_n_oen_o),
    .v5c_mode_o       (v5c_mode_o)
  );

  sm_readback sm_readback_inst (
    .epb_clk      (epb_clk),
    .wb_rst_i     (wb_rst_i),
    .cmd_i        (cmd),
    .pins_i       (pins),
    .status_i     (status),
    .byte_count_i (byte_count),
    .wb_ack_o     (wb_ack_o),
    .wb_dat_o     (wb_dat_o)
  );

endmodule

// ==== sm_readback.sv ====
`timescale 1ns/1ns
`include "sm_consts.svh"

module sm_readback (
  input  logic               epb_clk,
  input  logic               wb_rst_i,
  input  sm_pkg::sm_cmd_t    cmd_i,
  input  sm_pkg::sm_pins_t   pins_i,
  input  sm_pkg::sm_status_t status_i,
  input  logic [7:0]         byte_count_i,
  output logic               wb_ack_o,
  output logic [7:0]         wb_dat_o
);
  import sm_pkg::*;

  logic       cmd_vld;
  logic [7:0] rd_mux;

  assign cmd_vld = (cmd_i.op != OP_NONE);

  always_comb begin
    case (cmd_i.adr)
      `SM_REG_STATUS: rd_mux = {3'b0, status_i};
      `SM_REG_OREGS:  rd_mux = {5'b0, pins_i.rdwr_n, pins_i.init_n_o, pins_i.prog_n};
      `SM_REG_DATA:   rd_mux = 8'b0; // no readback path
      `SM_REG_CTRL:   rd_mux = {7'b0, pins_i.init_n_oen};
      `SM_REG_COUNT:  rd_mux = byte_count_i;
      default:        rd_mux = 8'b0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sampled on the same edge that executes a write, so reads see old state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge epb_clk) begin
    if (wb_rst_i)
      wb_ack_o <= 1'b0;
    else
      wb_ack_o <= cmd_vld;
  end

  always_ff @(posedge epb_clk) begin
    if (cmd_vld)
      wb_dat_o <= rd_mux; // holds between acks
  end

  a_ack_pulse: assert property (@(posedge epb_clk) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

// ==== sm_port_ctrl.sv ====
`timescale 1ns/1ns
`include "sm_consts.svh"

module sm_port_ctrl (
  input  logic               epb_clk,
  input  logic               wb_rst_i,
  input  sm_pkg::sm_cmd_t    cmd_i,
  input  logic               sm_cs_n_i,
  input  logic               sm_busy_i,
  input  logic               v5c_done_i,
  input  logic               v5c_busy_i,
  input  logic               v5c_init_n_i,
  output sm_pkg::sm_pins_t   pins_o,
  output sm_pkg::sm_status_t status_o,
  output logic [7:0]         byte_count_o,
  output logic [7:0]         v5c_d_o,
  output logic               v5c_cs_n_o,
  output logic               v5c_prog_n_o,
  output logic               v5c_rdwr_n_o,
  output logic               v5c_init_n_o,
  output logic               v5c_init_n_oen_o,
  output logic [2:0]         v5c_mode_o
);
  import sm_pkg::*;

  sm_pins_t   pins_q;
  logic [7:0] data_q;
  logic       cs_pulse_q;
  logic [7:0] count_q;
  logic       crc_err_q;
  logic       wr_oregs;
  logic       wr_data;
  logic       wr_ctrl;
  logic       prog_clr;
  logic       crc_set;

  assign wr_oregs = (cmd_i.op == OP_WR_OREGS);
  assign wr_data  = (cmd_i.op == OP_WR_DATA);
  assign wr_ctrl  = (cmd_i.op == OP_WR_CTRL);
  assign prog_clr = wr_oregs & ~cmd_i.data[`SM_OREGS_PROG_BIT];

  // init_n dropping once bytes are going in means a crc failure
  assign crc_set = ~v5c_init_n_i & pins_q.prog_n & (count_q != 8'd0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pin registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge epb_clk) begin
    if (wb_rst_i) begin
      pins_q <= '{rdwr_n: 1'b0, init_n_o: 1'b1, prog_n: 1'b1, init_n_oen: 1'b1};
    end else begin
      if (wr_oregs) begin
        pins_q.prog_n   <= cmd_i.data[`SM_OREGS_PROG_BIT];
        pins_q.init_n_o <= cmd_i.data[`SM_OREGS_INIT_BIT];
        pins_q.rdwr_n   <= cmd_i.data[`SM_OREGS_RDWR_BIT];
      end
      if (wr_ctrl)
        pins_q.init_n_oen <= cmd_i.data[`SM_CTRL_OEN_BIT];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data byte and chip select strobe
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge epb_clk) begin
    if (wr_data)
      data_q <= cmd_i.data; // held until next byte
  end

  always_ff @(posedge epb_clk) begin
    if (wb_rst_i)
      cs_pulse_q <= 1'b0;
    else
      cs_pulse_q <= wr_data;
  end

  always_ff @(posedge epb_clk) begin
    if (wb_rst_i)
      count_q <= 8'd0;
    else if (prog_clr)
      count_q <= 8'd0;
    else if (wr_data)
      count_q <= count_q + 8'd1; // wraps at 256
  end

  always_ff @(posedge epb_clk) begin
    if (wb_rst_i)
      crc_err_q <= 1'b0;
    else if (wr_ctrl && cmd_i.data[`SM_CTRL_CRC_CLR_BIT])
      crc_err_q <= 1'b0;
    else if (crc_set)
      crc_err_q <= 1'b1;
  end

  assign pins_o       = pins_q;
  assign byte_count_o = count_q;
  assign status_o     = '{crc_err:    crc_err_q,
                          sm_busy:    sm_busy_i,
                          v5c_busy:   v5c_busy_i,
                          v5c_done:   v5c_done_i,
                          v5c_init_n: v5c_init_n_i};

  assign v5c_d_o          = data_q;
  assign v5c_cs_n_o       = sm_cs_n_i & ~cs_pulse_q; // serial port or host
  assign v5c_prog_n_o     = pins_q.prog_n;
  assign v5c_rdwr_n_o     = pins_q.rdwr_n;
  assign v5c_init_n_o     = pins_q.init_n_o;
  assign v5c_init_n_oen_o = pins_q.init_n_oen;
  assign v5c_mode_o       = `SM_MODE_SLAVE_MAP;

  a_cs_pulse_one: assert property (@(posedge epb_clk) disable iff (wb_rst_i)
    cs_pulse_q |=> !cs_pulse_q);

endmodule

// ==== sm_reg_decode.sv ====
`timescale 1ns/1ns
`include "sm_consts.svh"

module sm_reg_decode (
  input  logic            epb_clk,
  input  logic            wb_rst_i,
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic            wb_we_i,
  input  logic [2:0]      wb_adr_i,
  input  logic [7:0]      wb_dat_i,
  input  logic            wb_ack_i,
  output sm_pkg::sm_cmd_t cmd_o
);
  import sm_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT_ACK,
    ST_RELEASE
  } state_e;

  state_e     state_q;
  logic       pending;
  logic       take;
  logic       req_we_q;
  logic [2:0] req_adr_q;
  logic [7:0] req_dat_q;

  function automatic sm_op_e decode_op(input logic we, input logic [2:0] adr);
    sm_op_e op;
    op = OP_READ; // reads, and writes to read-only regs
    if (we) begin
      case (adr)
        `SM_REG_OREGS: op = OP_WR_OREGS;
        `SM_REG_DATA:  op = OP_WR_DATA;
        `SM_REG_CTRL:  op = OP_WR_CTRL;
        default:       op = OP_READ;
      endcase
    end
    return op;
  endfunction

  assign pending = (state_q != ST_IDLE);
  assign take    = wb_cyc_i & wb_stb_i & ~pending;

  always_ff @(posedge epb_clk) begin
    if (take) begin
      req_we_q  <= wb_we_i;
      req_adr_q <= wb_adr_i;
      req_dat_q <= wb_dat_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one command per strobe, held off until the strobe drops after the ack
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge epb_clk) begin
    if (wb_rst_i) begin
      state_q  <= ST_IDLE;
      cmd_o.op <= OP_NONE;
    end else begin
      cmd_o.op <= OP_NONE; // single cycle
      case (state_q)
        ST_IDLE: begin
          if (take)
            state_q <= ST_ISSUE;
        end
        ST_ISSUE: begin
          cmd_o.op   <= decode_op(req_we_q, req_adr_q);
          cmd_o.adr  <= req_adr_q;
          cmd_o.data <= req_dat_q;
          state_q    <= ST_WAIT_ACK;
        end
        ST_WAIT_ACK: begin
          if (wb_ack_i)
            state_q <= (wb_cyc_i & wb_stb_i) ? ST_RELEASE : ST_IDLE;
        end
        ST_RELEASE: begin
          if (!(wb_cyc_i & wb_stb_i))
            state_q <= ST_IDLE; // master let go
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  a_cmd_single: assert property (@(posedge epb_clk) disable iff (wb_rst_i)
    (cmd_o.op != OP_NONE) |=> (cmd_o.op == OP_NONE) && wb_ack_i);

endmodule

// ==== sm_pkg.sv ====
package sm_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // command passed from decode to the execute and result stages
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [2:0] {
    OP_NONE     = 3'd0,
    OP_READ     = 3'd1, // also used for ignored writes
    OP_WR_OREGS = 3'd2,
    OP_WR_DATA  = 3'd3,
    OP_WR_CTRL  = 3'd4
  } sm_op_e;

  typedef struct packed {
    sm_op_e     op;
    logic [2:0] adr;
    logic [7:0] data;
  } sm_cmd_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // device side state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic rdwr_n;
    logic init_n_o;
    logic prog_n;
    logic init_n_oen; // tri-state enable, active low
  } sm_pins_t;

  typedef struct packed {
    logic crc_err;    // sticky
    logic sm_busy;
    logic v5c_busy;
    logic v5c_done;
    logic v5c_init_n;
  } sm_status_t;

endpackage

// ==== sm_consts.svh ====
`ifndef SM_CONSTS_SVH
`define SM_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SM_REG_STATUS 3'd0
`define SM_REG_OREGS  3'd1
`define SM_REG_DATA   3'd2
`define SM_REG_CTRL   3'd3
`define SM_REG_COUNT  3'd4

`define SM_MODE_SLAVE_MAP 3'b110 // slave selectmap

// field positions in written data
`define SM_OREGS_PROG_BIT    0
`define SM_OREGS_INIT_BIT    1
`define SM_OREGS_RDWR_BIT    2
`define SM_CTRL_OEN_BIT      0
`define SM_CTRL_CRC_CLR_BIT  1

`endif
